//--- sources.f
+incdir+common
common/immPkg.sv
common/stageIf.sv
decode/immDecode.sv
execute/immExecute.sv
verilog/resultStage.sv
verilog/immUnitTop.sv
testbench/immUnit_sva.sv
testbench/immUnitTb.sv

//--- Bender.yml
package:
  name: immUnit

sources:
  - include_dirs:
      - common
    files:
      - common/immPkg.sv
      - common/stageIf.sv
      - decode/immDecode.sv
      - execute/immExecute.sv
      - verilog/resultStage.sv
      - verilog/immUnitTop.sv
      - target: test
        include_dirs:
          - common
        files:
          - testbench/immUnit_sva.sv
          - testbench/immUnitTb.sv

//--- testbench/immUnitTb.sv
`timescale 1ns/100ps
`include "imm_macros.svh"

module immUnitTb;
	import immPkg::*;

	localparam int clkPeriod = 4;
	localparam int numTests = 6;

	logic        clk;
	logic        reset;
	logic        fetchValid;
	parcel_t     parcel0;
	parcel_t     parcel1;
	parcel_t     parcel2;
	parcel_t     parcel3;
	parcel_t     parcel4;
	value_t      operand;
	logic        resultValid;
	value_t      result;
	pcInc_t      pcInc;
	logic        illegal;
	logic [31:0] pc;

	integer      seed = 32'hcd93;
	int          cycle = 0;
	int          errors;
	int          passCount;
	int          failCount;
	logic [31:0] expPc;

	// Expected results in issue order with one entry per instruction in flight
	value_t expValue[$];
	pcInc_t expLen[$];
	logic   expIll[$];
	int     expCycle[$];

	immUnitTop uut (.*);

	initial clk = 1'b0;
	always #(clkPeriod / 2) clk = ~clk;

	// Counts rising edges, read on falling edges only
	always @(posedge clk) cycle <= cycle + 1;

	// ============================================================
	// Reference model and parcel builders
	// ============================================================

	function automatic value_t signExtend(value_t x, int width);
		value_t r;
		r = x;
		for (int i = width; i < `IMM_VALUE_BITS; i++)
			r[i] = x[width - 1];
		return r;
	endfunction

	function automatic logic prefixMatches(logic [39:0] p, prefixSize_t size);
		return (p[6:0] == PFX) && (p[9:7] == size);
	endfunction

	// Immediate, length and outcome of one instruction from its five parcels
	function automatic void refModel(input logic [39:0] p0, p1, p2, p3, p4,
			input value_t opnd, output value_t val, output pcInc_t len, output logic ill);
		value_t imm;
		value_t ext;
		logic [6:0] sh;
		imm = '0;
		case (p0[6:0])
			ADDI: imm = signExtend({p0[38:32], p0[31:24]}, 15);
			ANDI: imm = value_t'({p0[38:32], p0[31:24]}) | (~value_t'(0) << 15);
			ORI, EORI: imm = value_t'({p0[38:32], p0[31:24]});
			LSLI, LSRI, ASRI: imm = value_t'(p0[30:24]);
			LOAD, STORE: imm = signExtend({p0[36:31], p0[30:24]}, 13);
			default: imm = '0;
		endcase
		len = 5;
		if (prefixMatches(p1, PFX_LO)) begin
			imm = signExtend(p1[39:8], 32);
			len = 10;
			if (prefixMatches(p2, PFX_MID)) begin
				ext = signExtend(p2[39:8], 32);
				imm[127:32] = ext[95:0];
				len = 15;
				if (prefixMatches(p3, PFX_HI)) begin
					imm[127:64] = {p4[39:8], p3[39:8]};
					len = 20;
				end
			end
		end
		else if (prefixMatches(p1, PFX_MID)) begin
			imm = signExtend(p1[39:8], 32) << 32;
			len = 10;
			if (prefixMatches(p2, PFX_HI)) begin
				ext = signExtend(p2[39:8], 32);
				imm[127:64] = ext[63:0];
				len = 15;
			end
		end
		else if (prefixMatches(p1, PFX_HI)) begin
			imm = signExtend(p1[39:8], 32) << 64;
			len = 10;
		end
		sh = imm[6:0];
		ill = 1'b0;
		case (p0[6:0])
			ADDI, LOAD, STORE: val = opnd + imm;
			ANDI: val = opnd & imm;
			ORI: val = opnd | imm;
			EORI: val = opnd ^ imm;
			LSLI: val = opnd << sh;
			LSRI: val = opnd >> sh;
			// Logical shift, then fill the vacated top bits with the sign
			ASRI: val = opnd[127] ? ((opnd >> sh) | ~(~value_t'(0) >> sh)) : (opnd >> sh);
			NOP: val = '0;
			default: begin
				val = '0;
				ill = 1'b1;
			end
		endcase
	endfunction

	function automatic logic [39:0] riParcel(opcode_t op, logic [14:0] imm);
		logic [39:0] p;
		p = '0;
		p[6:0] = op;
		p[31:24] = imm[7:0];
		p[38:32] = imm[14:8];
		return p;
	endfunction

	function automatic logic [39:0] lsParcel(opcode_t op, logic [12:0] disp);
		logic [39:0] p;
		p = '0;
		p[6:0] = op;
		p[30:24] = disp[6:0];
		p[36:31] = disp[12:7];
		return p;
	endfunction

	function automatic logic [39:0] shParcel(opcode_t op, logic [6:0] amount);
		logic [39:0] p;
		p = '0;
		p[6:0] = op;
		p[30:24] = amount;
		return p;
	endfunction

	function automatic logic [39:0] pfxParcel(prefixSize_t size, logic [31:0] payload);
		logic [39:0] p;
		p = {payload, 1'b0, PFX};
		// Size field overlaps the two lowest payload bits
		p[9:7] = size;
		return p;
	endfunction

	function automatic value_t randomValue();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	// ============================================================
	// Compare tasks
	// ============================================================

	task automatic checkValue(string what, value_t got, value_t exp);
		if (got !== exp) begin
			$display("error %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic checkInc(string what, pcInc_t got, pcInc_t exp);
		if (got !== exp) begin
			$display("error %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic checkFlag(string what, logic got, logic exp);
		if (got !== exp) begin
			$display("error %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic checkPc(string what, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("error %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// ============================================================
	// Driving and collecting
	// ============================================================

	task automatic flushExpected();
		expValue.delete();
		expLen.delete();
		expIll.delete();
		expCycle.delete();
	endtask

	// Outputs are stable at the falling edge, so results are taken there
	task automatic collect();
		if (resultValid) begin
			if (expValue.size() == 0) begin
				$display("a result came out at %0t with no instruction in flight", $time);
				errors++;
			end
			else begin
				if (cycle != expCycle[0]) begin
					$display("error %0t: result arrived at cycle %0d, expected %0d",
						$time, cycle, expCycle[0]);
					errors++;
				end
				expPc = expPc + expLen[0];
				checkValue("result", result, expValue.pop_front());
				checkInc("pcInc", pcInc, expLen.pop_front());
				checkFlag("illegal", illegal, expIll.pop_front());
				void'(expCycle.pop_front());
				checkPc("pc", pc, expPc);
			end
		end
	endtask

	task automatic issue(logic [39:0] p0, p1, p2, p3, p4, value_t opnd);
		value_t val;
		pcInc_t len;
		logic   ill;
		@(negedge clk);
		collect();
		refModel(p0, p1, p2, p3, p4, opnd, val, len, ill);
		fetchValid  = 1'b1;
		parcel0.raw = p0;
		parcel1.raw = p1;
		parcel2.raw = p2;
		parcel3.raw = p3;
		parcel4.raw = p4;
		operand     = opnd;
		expValue.push_back(val);
		expLen.push_back(len);
		expIll.push_back(ill);
		// Three registers between the sampling edge and the result
		expCycle.push_back(cycle + 3);
	endtask

	task automatic idle();
		@(negedge clk);
		collect();
		fetchValid = 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (expValue.size() != 0 && waited < 10) begin
			idle();
			waited++;
		end
		if (expValue.size() != 0) begin
			$display("result never became valid, %0d instructions lost at %0t",
				expValue.size(), $time);
			errors++;
			flushExpected();
		end
	endtask

	task automatic finishTest(string name);
		if (errors == 0) begin
			$display("%s: passed", name);
			passCount++;
		end
		else begin
			$display("%s: failed with %0d errors", name, errors);
			failCount++;
		end
		errors = 0;
	endtask

	// ============================================================
	// Directed tests
	// ============================================================

	// Zero parcels decode as NOP and never as a prefix
	task automatic testBaseImm();
		logic [39:0] none;
		none = '0;
		issue(riParcel(ADDI, 15'h7ffd), none, none, none, none, randomValue());
		issue(riParcel(ANDI, 15'h1234), none, none, none, none, randomValue());
		issue(riParcel(ORI, 15'h4321), none, none, none, none, randomValue());
		issue(riParcel(EORI, 15'h7abc), none, none, none, none, randomValue());
		issue(lsParcel(LOAD, 13'h1fec), none, none, none, none, randomValue());
		issue(lsParcel(STORE, 13'h1fff), none, none, none, none, randomValue());
		drain();
		finishTest("base immediates");
	endtask

	task automatic testShifts();
		opcode_t     ops[3] = '{LSLI, LSRI, ASRI};
		logic [6:0]  amounts[4] = '{7'd0, 7'd1, 7'd63, 7'd127};
		logic [39:0] none;
		value_t      opnd;
		none = '0;
		foreach (ops[i]) begin
			foreach (amounts[j]) begin
				opnd = randomValue();
				// Odd positions give the arithmetic shift a negative operand
				if (ops[i] == ASRI)
					opnd[127] = j[0];
				issue(shParcel(ops[i], amounts[j]), none, none, none, none, opnd);
			end
		end
		drain();
		finishTest("shifts");
	endtask

	task automatic testPrefix();
		logic [39:0] base;
		logic [39:0] none;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		none = '0;
		base = riParcel(ADDI, 15'h0123);
		a = 32'hfedc_ba98;
		b = $random(seed);
		c = $random(seed);
		d = $random(seed);
		issue(base, pfxParcel(PFX_LO, a), none, none, none, randomValue());
		issue(base, pfxParcel(PFX_LO, b), pfxParcel(PFX_MID, a), none, none, randomValue());
		issue(base, pfxParcel(PFX_LO, a), pfxParcel(PFX_MID, b), pfxParcel(PFX_HI, c),
			pfxParcel(PFX_LO, d), randomValue());
		issue(base, pfxParcel(PFX_MID, a), none, none, none, randomValue());
		issue(base, pfxParcel(PFX_MID, c), pfxParcel(PFX_HI, a), none, none, randomValue());
		issue(base, pfxParcel(PFX_HI, a), none, none, none, randomValue());
		// Wrong order ends the chain after the first prefix
		issue(base, pfxParcel(PFX_LO, d), pfxParcel(PFX_HI, b), none, none, randomValue());
		drain();
		finishTest("prefix chains");
	endtask

	task automatic testPipeline();
		opcode_t     kinds[9] = '{ADDI, ANDI, ORI, EORI, LSLI, LSRI, ASRI, LOAD, STORE};
		logic [39:0] p;
		logic [39:0] none;
		int          idx;
		none = '0;
		for (int k = 0; k < 10; k++) begin
			// Two gaps break the stream into bursts
			if (k == 4 || k == 7) begin
				idle();
				idle();
			end
			idx = $unsigned($random(seed)) % 9;
			p = {$random(seed), 1'b0, kinds[idx]};
			issue(p, none, none, none, none, randomValue());
		end
		drain();
		finishTest("pipelining");
	endtask

	task automatic testPcIllegal();
		logic [39:0] none;
		none = '0;
		issue(riParcel(ADDI, 15'd9), none, none, none, none, randomValue());
		// Unknown opcode with a prefix still skips both parcels
		issue({$random(seed), 1'b0, 7'h33}, pfxParcel(PFX_LO, 32'h1111_2222), none, none,
			none, randomValue());
		issue(pfxParcel(PFX_LO, 32'h8765_4321), none, none, none, none, randomValue());
		issue(none, pfxParcel(PFX_MID, 32'h0f0f_0f0f), none, none, none, randomValue());
		drain();
		checkPc("pc after sequence", pc, expPc);
		finishTest("pc and illegal opcodes");
	endtask

	task automatic testMidReset();
		logic [39:0] none;
		none = '0;
		issue(riParcel(ORI, 15'h00ff), none, none, none, none, randomValue());
		issue(riParcel(EORI, 15'h0f00), none, none, none, none, randomValue());
		@(negedge clk);
		fetchValid = 1'b0;
		reset = 1'b1;
		// Both instructions in flight would retire inside this window
		repeat (5) begin
			@(negedge clk);
			checkFlag("resultValid in reset", resultValid, 1'b0);
		end
		checkPc("pc in reset", pc, `IMM_PC_RESET);
		reset = 1'b0;
		// Instructions in flight are lost with the reset
		flushExpected();
		expPc = `IMM_PC_RESET;
		issue(riParcel(ADDI, 15'h0042), none, none, none, none, randomValue());
		drain();
		finishTest("reset in mid-run");
	endtask

	// ============================================================
	// Sequence and watchdog
	// ============================================================

	initial begin
		reset = 1'b1;
		fetchValid = 1'b0;
		parcel0 = '0;
		parcel1 = '0;
		parcel2 = '0;
		parcel3 = '0;
		parcel4 = '0;
		operand = '0;
		errors = 0;
		passCount = 0;
		failCount = 0;
		expPc = `IMM_PC_RESET;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		testBaseImm();
		testShifts();
		testPrefix();
		testPipeline();
		testPcIllegal();
		testMidReset();
		$display("tests passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Budget of 40 cycles for each test
	initial begin
		#(40 * numTests * clkPeriod);
		$display("watchdog expired before the tests finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- testbench/immUnit_sva.sv
`timescale 1ns/100ps

module immUnitSva (
	input logic        clk,
	input logic        reset,
	input logic        fetchValid,
	input logic        resultValid,
	input logic [31:0] pc
);

	// Every fetch retires three edges later, and nothing retires without one
	resultLatency: assert property (@(posedge clk) disable iff (reset)
		fetchValid |-> ##3 resultValid)
		else $error("resultValid did not follow fetchValid by three cycles");

	noStrayResult: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> $past(fetchValid, 3))
		else $error("resultValid without a fetch three cycles before");

	quietInReset: assert property (@(posedge clk) reset |=> !resultValid)
		else $error("resultValid high during reset");

	// The program counter only moves when an instruction retires
	pcOnRetire: assert property (@(posedge clk) disable iff (reset)
		$changed(pc) |-> resultValid)
		else $error("pc changed without a retired instruction");

endmodule

bind immUnitTop immUnitSva sva (
	.clk         (clk),
	.reset       (reset),
	.fetchValid  (fetchValid),
	.resultValid (resultValid),
	.pc          (pc)
);

//--- verilog/immUnitTop.sv
`timescale 1ns/100ps

module immUnitTop (
	input  logic            clk,
	input  logic            reset,
	input  logic            fetchValid,
	input  immPkg::parcel_t parcel0,
	input  immPkg::parcel_t parcel1,
	input  immPkg::parcel_t parcel2,
	input  immPkg::parcel_t parcel3,
	input  immPkg::parcel_t parcel4,
	input  immPkg::value_t  operand,
	output logic            resultValid,
	output immPkg::value_t  result,
	output immPkg::pcInc_t  pcInc,
	output logic            illegal,
	output logic [31:0]     pc
);

	// ============================================================
	// Three stages, one register each
	// ============================================================

	decodeIf decodeBus ();
	execIf   execBus ();

	// Immediate assembly and length count
	immDecode uDecode (
		.clk        (clk),
		.reset      (reset),
		.fetchValid (fetchValid),
		.parcel0    (parcel0),
		.parcel1    (parcel1),
		.parcel2    (parcel2),
		.parcel3    (parcel3),
		.parcel4    (parcel4),
		.operand    (operand),
		.out        (decodeBus.source)
	);

	immExecute uExecute (
		.clk   (clk),
		.reset (reset),
		.in    (decodeBus.sink),
		.out   (execBus.source)
	);

	// Retire and track the program counter
	resultStage uResult (
		.clk         (clk),
		.reset       (reset),
		.in          (execBus.sink),
		.resultValid (resultValid),
		.illegal     (illegal),
		.result      (result),
		.pcInc       (pcInc),
		.pc          (pc)
	);

endmodule

//--- verilog/resultStage.sv
`timescale 1ns/100ps
`include "imm_macros.svh"

module resultStage (
	input  logic           clk,
	input  logic           reset,
	execIf.sink            in,
	output logic           resultValid,
	output logic           illegal,
	output immPkg::value_t result,
	output immPkg::pcInc_t pcInc,
	output logic [31:0]    pc
);
	import immPkg::*;

	// Retire strobe, illegal flag and program counter
	always_ff @(posedge clk) begin
		if (reset) begin
			resultValid <= 1'b0;
			illegal     <= 1'b0;
			pc          <= `IMM_PC_RESET;
		end
		else begin
			resultValid <= in.valid;
			if (in.valid) begin
				illegal <= in.illegal;
				// Illegal instructions still move pc past all their parcels
				pc      <= pc + {27'd0, in.pcInc};
			end
		end
	end

	// Retired value and its length
	always_ff @(posedge clk) begin
		if (in.valid) begin
			result <= in.value;
			pcInc  <= in.pcInc;
		end
	end

endmodule

//--- execute/immExecute.sv
`timescale 1ns/100ps

module immExecute (
	input  logic   clk,
	input  logic   reset,
	decodeIf.sink  in,
	execIf.source  out
);
	import immPkg::*;

	logic [6:0] shiftAmount;
	value_t     nextValue;
	logic       nextIllegal;

	// Shifts use only the low seven bits of the immediate
	assign shiftAmount = in.imm[6:0];

	// ============================================================
	// Operation select
	// ============================================================

	always_comb begin
		nextValue   = '0;
		nextIllegal = 1'b0;
		case (in.opcode)
			// Loads and stores only form the effective address here
			ADDI, LOAD, STORE:
				nextValue = in.operand + in.imm;
			ANDI:
				nextValue = in.operand & in.imm;
			ORI:
				nextValue = in.operand | in.imm;
			EORI:
				nextValue = in.operand ^ in.imm;
			LSLI:
				nextValue = in.operand << shiftAmount;
			LSRI:
				nextValue = in.operand >> shiftAmount;
			ASRI:
				nextValue = value_t'($signed(in.operand) >>> shiftAmount);
			NOP:
				nextValue = '0;
			// A leading prefix lands here too, value stays zero
			default:
				nextIllegal = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out.valid   <= 1'b0;
			out.illegal <= 1'b0;
		end
		else begin
			out.valid <= in.valid;
			if (in.valid)
				out.illegal <= nextIllegal;
		end
	end

	// Result and length follow the instruction down the pipe
	always_ff @(posedge clk) begin
		if (in.valid) begin
			out.value <= nextValue;
			out.pcInc <= in.pcInc;
		end
	end

endmodule

//--- decode/immDecode.sv
`timescale 1ns/100ps
`include "imm_macros.svh"

module immDecode (
	input  logic            clk,
	input  logic            reset,
	input  logic            fetchValid,
	input  immPkg::parcel_t parcel0,
	input  immPkg::parcel_t parcel1,
	input  immPkg::parcel_t parcel2,
	input  immPkg::parcel_t parcel3,
	input  immPkg::parcel_t parcel4,
	input  immPkg::value_t  operand,
	decodeIf.source         out
);
	import immPkg::*;

	// Sign bit of a prefix payload
	localparam int signBit = `IMM_PARCEL_BITS - 1;
	localparam pcInc_t oneParcel = pcInc_t'(`IMM_PARCEL_BYTES);

	value_t baseImm;
	value_t chainImm;
	pcInc_t chainLen;

	// A prefix only counts when both its opcode and its size match
	function automatic logic isPrefix(parcel_t p, prefixSize_t size);
		return (p.sized.opcode == PFX) && (p.sized.size == size);
	endfunction

	// Payload of a prefix, sign-extended to the full immediate
	function automatic value_t payloadExt(parcel_t p);
		return {{(`IMM_VALUE_BITS - 32){p.raw[signBit]}}, p.pfx.payload};
	endfunction

	// ============================================================
	// Base immediate from the leading parcel
	// ============================================================

	always_comb begin
		case (parcel0.sized.opcode)
			ADDI:
				baseImm = {{113{parcel0.ri.immHi[6]}}, parcel0.ri.immHi, parcel0.ri.immLo};
			// AND keeps the upper operand bits so pad with ones
			ANDI:
				baseImm = {{113{1'b1}}, parcel0.ri.immHi, parcel0.ri.immLo};
			ORI, EORI:
				baseImm = {113'd0, parcel0.ri.immHi, parcel0.ri.immLo};
			LSLI, LSRI, ASRI:
				baseImm = {121'd0, parcel0.sh.amount};
			// Displacement is 13 bits with its sign in dispHi
			LOAD, STORE:
				baseImm = {{115{parcel0.ls.dispHi[5]}}, parcel0.ls.dispHi, parcel0.ls.dispLo};
			default:
				baseImm = '0;
		endcase
	end

	// ============================================================
	// Prefix chain and instruction length
	// ============================================================

	always_comb begin
		chainImm = baseImm;
		chainLen = oneParcel;
		if (isPrefix(parcel1, PFX_LO)) begin
			// Low prefix replaces the whole immediate
			chainImm = payloadExt(parcel1);
			chainLen = chainLen + oneParcel;
			if (isPrefix(parcel2, PFX_MID)) begin
				chainImm[127:32] = {{64{parcel2.raw[signBit]}}, parcel2.pfx.payload};
				chainLen = chainLen + oneParcel;
				// The final parcel carries the top word and is not checked
				if (isPrefix(parcel3, PFX_HI)) begin
					chainImm[127:64] = {parcel4.pfx.payload, parcel3.pfx.payload};
					chainLen = chainLen + oneParcel;
				end
			end
		end
		else if (isPrefix(parcel1, PFX_MID)) begin
			chainImm = payloadExt(parcel1) << 32;
			chainLen = chainLen + oneParcel;
			if (isPrefix(parcel2, PFX_HI)) begin
				chainImm[127:64] = {{32{parcel2.raw[signBit]}}, parcel2.pfx.payload};
				chainLen = chainLen + oneParcel;
			end
		end
		else if (isPrefix(parcel1, PFX_HI)) begin
			chainImm = payloadExt(parcel1) << 64;
			chainLen = chainLen + oneParcel;
		end
	end

	// Valid strobe is the only control state here
	always_ff @(posedge clk) begin
		if (reset)
			out.valid <= 1'b0;
		else
			out.valid <= fetchValid;
	end

	// Payload holds its last value while no instruction arrives
	always_ff @(posedge clk) begin
		if (fetchValid) begin
			out.opcode  <= parcel0.sized.opcode;
			out.imm     <= chainImm;
			out.operand <= operand;
			out.pcInc   <= chainLen;
		end
	end

endmodule

//--- common/stageIf.sv
`timescale 1ns/100ps

// Decode to execute stage, one valid strobe per instruction
interface decodeIf;
	import immPkg::*;

	logic    valid;
	opcode_t opcode;
	value_t  imm;
	value_t  operand;
	pcInc_t  pcInc;

	modport source(output valid, opcode, imm, operand, pcInc);
	modport sink(input valid, opcode, imm, operand, pcInc);
endinterface

// Execute to result stage
interface execIf;
	import immPkg::*;

	logic   valid;
	value_t value;
	pcInc_t pcInc;
	logic   illegal;

	modport source(output valid, value, pcInc, illegal);
	modport sink(input valid, value, pcInc, illegal);
endinterface

//--- common/immPkg.sv
`include "imm_macros.svh"

package immPkg;

	// Major opcode in bits 6:0 of every parcel
	// Values not listed here are illegal
	typedef enum logic [6:0] {
		NOP   = 7'h00,
		ADDI  = 7'h04,
		ANDI  = 7'h08,
		ORI   = 7'h09,
		EORI  = 7'h0A,
		LSLI  = 7'h10,
		LSRI  = 7'h11,
		ASRI  = 7'h12,
		LOAD  = 7'h40,
		STORE = 7'h48,
		PFX   = 7'h7F
	} opcode_t;

	// Which slice of the immediate a prefix parcel supplies
	typedef enum logic [2:0] {
		PFX_LO  = 3'd0,
		PFX_MID = 3'd1,
		PFX_HI  = 3'd2
	} prefixSize_t;

	typedef logic [`IMM_VALUE_BITS-1:0]  value_t;
	typedef logic [4:0]                  pcInc_t;
	typedef logic [`IMM_PARCEL_BITS-1:0] rawParcel_t;

	// ============================================================
	// Field views of one parcel, all 40 bits wide
	// ============================================================

	// Prefix payload sits above bit 7
	typedef struct packed {
		logic [31:0] payload;
		logic        spare;
		opcode_t     opcode;
	} pfxView_t;

	// Size field of a prefix overlaps the low payload bits
	typedef struct packed {
		logic [29:0] spare;
		prefixSize_t size;
		opcode_t     opcode;
	} sizeView_t;

	// Register-immediate form, sign of the immediate at bit 38
	typedef struct packed {
		logic        spare;
		logic [6:0]  immHi;
		logic [7:0]  immLo;
		logic [10:0] rsvd;
		logic [5:0]  rt;
		opcode_t     opcode;
	} riView_t;

	// Load/store form with sign at bit 36
	typedef struct packed {
		logic [2:0]  spare;
		logic [5:0]  dispHi;
		logic [6:0]  dispLo;
		logic [10:0] rsvd;
		logic [5:0]  rt;
		opcode_t     opcode;
	} lsView_t;

	typedef struct packed {
		logic [8:0]  spare;
		logic [6:0]  amount;
		logic [10:0] rsvd;
		logic [5:0]  rt;
		opcode_t     opcode;
	} shView_t;

	typedef union packed {
		rawParcel_t raw;
		pfxView_t   pfx;
		sizeView_t  sized;
		riView_t    ri;
		lsView_t    ls;
		shView_t    sh;
	} parcel_t;

endpackage

//--- common/imm_macros.svh
`ifndef IMM_MACROS_SVH
`define IMM_MACROS_SVH

// ============================================================
// Widths fixed by the parcel format
// ============================================================

// One instruction parcel
`define IMM_PARCEL_BITS 40

// Register operand and assembled immediate
`define IMM_VALUE_BITS 128

// Program counter step for each parcel of an instruction
`define IMM_PARCEL_BYTES 5

// Program counter value after reset
`define IMM_PC_RESET 32'h0000_1000

`endif
